// ==== common/nic_pkg.sv ====
// Shared types for the slotted ring network
// Every RTL block and the testbench take the packet layout and the valid rule from here
// A slot is empty when both its source and destination ids are zero

package nic_pkg;

	// ====================
	// Field widths
	// ====================

	// Node ids use six bits, so up to 63 nodes fit with zero kept as "no node"
	localparam int ID_W = 6;

	// Hop counter width, which bounds the largest usable MAX_AGE
	localparam int AGE_W = 3;

	// Packet type code, carried around the ring untouched
	localparam int TYPE_W = 6;

	// Largest age the counter can hold
	localparam int AGE_MAX_REPR = (1 << AGE_W) - 1;

	// Largest node id that still fits in a node_id_t
	localparam int ID_MAX_REPR = (1 << ID_W) - 1;

	// ====================
	// Types
	// ====================

	// A node id, also used for the source and destination fields
	typedef logic [ID_W-1:0] node_id_t;

	// Number of hops a packet has made since it was placed on the ring
	typedef logic [AGE_W-1:0] age_t;

	// Type code of a packet
	typedef logic [TYPE_W-1:0] pkt_type_t;

	// One ring slot
	// The destination sits in the top bits, the age in the bottom bits
	typedef struct packed {
		node_id_t  did;
		node_id_t  sid;
		pkt_type_t typ;
		age_t      age;
	} packet_t;

	// ====================
	// Valid rule
	// ====================

	// A slot holds a packet when either id is nonzero
	// The ager, the matcher and the node all decide slot occupancy through this one function
	function automatic logic pkt_valid(input packet_t pkt);
		return (pkt.sid != '0) || (pkt.did != '0);
	endfunction

endpackage

// ==== nic/nic_ager.sv ====
// Slot ager of one ring stop
// Registers the slot arriving from upstream and counts one hop on a valid packet
// A packet that arrives already at MAX_AGE is removed and a one-cycle drop is flagged

`timescale 1ns/1ps

module nic_ager #(
	parameter int MAX_AGE = 7
) (
	input  logic             clk_i,
	input  logic             reset_i,
	input  nic_pkg::packet_t slot_i,
	output nic_pkg::packet_t aged_o,
	output logic             drop_o
);

	import nic_pkg::*;

	// Incoming packet has made its last allowed hop
	logic    stale;
	packet_t aged_next;

	always_comb begin
		stale = pkt_valid(slot_i) && (slot_i.age == age_t'(MAX_AGE));
		// Empty and stale slots leave as all zero, so the next node sees a free slot
		aged_next = '0;
		if (pkt_valid(slot_i) && !stale) begin
			aged_next = slot_i;
			aged_next.age = slot_i.age + age_t'(1);
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			aged_o <= '0;
			drop_o <= 1'b0;
		end else begin
			aged_o <= aged_next;
			// One pulse per discarded packet
			drop_o <= stale;
		end
	end

endmodule

// ==== nic/nic_rx_match.sv ====
// Receive matcher of one ring stop
// Looks at the same upstream slot as the ager, in parallel with it
// Flags a delivery when the slot holds a valid packet addressed to this node
// The registered copy of the slot is the delivered packet

`timescale 1ns/1ps

module nic_rx_match (
	input  logic               clk_i,
	input  logic               reset_i,
	input  nic_pkg::packet_t   slot_i,
	input  nic_pkg::node_id_t  node_id_i,
	output logic               take_o,
	output nic_pkg::packet_t   rx_packet_o
);

	import nic_pkg::*;

	// Slot carries a packet for this node
	logic hit;

	always_comb begin
		// The valid check keeps an empty slot from matching, even with a zero id
		hit = pkt_valid(slot_i) && (slot_i.did == node_id_i);
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			take_o      <= 1'b0;
			rx_packet_o <= '0;
		end else begin
			// Strobe lasts one cycle because the slot moves on at the next edge
			take_o      <= hit;
			// The age seen here is the hop count minus one, since it was not yet bumped
			rx_packet_o <= slot_i;
		end
	end

endmodule

// ==== nic/nic_node.sv ====
// One stop of the slotted ring
// The ager and the receive matcher both register the upstream slot
// The node merges their results, matcher first, and drops its waiting
// transmit packet into the first slot that comes out free

`timescale 1ns/1ps

module nic_node #(
	parameter int NODE_ID = 1,
	parameter int MAX_AGE = 7
) (
	input  logic             clk_i,
	input  logic             reset_i,
	input  nic_pkg::packet_t ring_i,
	output nic_pkg::packet_t ring_o,
	input  logic             tx_strobe_i,
	input  nic_pkg::packet_t tx_packet_i,
	output logic             tx_busy_o,
	output logic             tx_overflow_o,
	output logic             rx_strobe_o,
	output logic             drop_strobe_o,
	output nic_pkg::packet_t rx_packet_o
);

	import nic_pkg::*;

	// ====================
	// Slot pipeline
	// ====================

	packet_t agr_slot;
	logic    agr_drop;
	logic    rx_take;
	packet_t rx_pkt;

	nic_ager #(
		.MAX_AGE (MAX_AGE)
	) u_ager (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.slot_i  (ring_i),
		.aged_o  (agr_slot),
		.drop_o  (agr_drop)
	);

	nic_rx_match u_rx_match (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.slot_i      (ring_i),
		.node_id_i   (node_id_t'(NODE_ID)),
		.take_o      (rx_take),
		.rx_packet_o (rx_pkt)
	);

	// ====================
	// Combine and insert
	// ====================

	// One-deep transmit hold register
	packet_t hold_pkt;
	logic    hold_full;

	// Slot after the receive decision, before any insertion
	packet_t slot_sel;
	// Held packet goes out on this cycle
	logic    insert;
	// Held packet, stamped for the ring
	packet_t tx_stamped;
	// A new strobe would find no room
	logic    busy;

	always_comb begin
		// Delivery frees the slot even when the ager saw it at MAX_AGE
		slot_sel = rx_take ? packet_t'('0) : agr_slot;
		insert = hold_full && !pkt_valid(slot_sel);

		tx_stamped = hold_pkt;
		tx_stamped.sid = node_id_t'(NODE_ID);
		tx_stamped.age = '0;

		ring_o = insert ? tx_stamped : slot_sel;

		// Busy drops in the same cycle the packet enters the ring
		busy = hold_full && !insert;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			hold_full     <= 1'b0;
			tx_overflow_o <= 1'b0;
		end else begin
			if (tx_strobe_i && !busy) begin
				// Either the register was empty or it empties on this edge
				hold_full <= 1'b1;
			end else if (insert) begin
				hold_full <= 1'b0;
			end
			// No back-pressure, so a strobe against a full register is lost
			tx_overflow_o <= tx_strobe_i && busy;
		end
	end

	// The packet register only loads on an accepted strobe
	always_ff @(posedge clk_i) begin
		if (tx_strobe_i && !busy) begin
			hold_pkt <= tx_packet_i;
		end
	end

	// ====================
	// Status outputs
	// ====================

	assign tx_busy_o     = busy;
	assign rx_strobe_o   = rx_take;
	assign rx_packet_o   = rx_pkt;
	// A packet delivered at its last hop counts as delivered, not dropped
	assign drop_strobe_o = agr_drop && !rx_take;

endmodule

// ==== hdl/nic_ring.sv ====
// Top level of the slotted ring network
// Builds NUM_NODES ring stops in a loop, so NUM_NODES slots circulate one hop per clock
// One injection port is shared by all nodes and steered by tx_node_i
// Status outputs are gathered into one bit or one packet per node

`timescale 1ns/1ps

module nic_ring #(
	parameter int NUM_NODES = 4,
	parameter int MAX_AGE   = 7
) (
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic                              tx_strobe_i,
	input  nic_pkg::node_id_t                 tx_node_i,
	input  nic_pkg::packet_t                  tx_packet_i,
	output logic             [NUM_NODES-1:0]  rx_strobe_o,
	output logic             [NUM_NODES-1:0]  drop_strobe_o,
	output logic             [NUM_NODES-1:0]  tx_busy_o,
	output logic             [NUM_NODES-1:0]  tx_overflow_o,
	output nic_pkg::packet_t [NUM_NODES-1:0]  rx_packet_o
);

	import nic_pkg::*;

	// ====================
	// Configuration checks
	// ====================

	// Every destination must be reachable before a packet ages out,
	// and the age counter and id field must hold the configured values
	if (MAX_AGE < NUM_NODES || MAX_AGE > AGE_MAX_REPR) begin : g_bad_age
		$error("MAX_AGE %0d does not suit %0d nodes", MAX_AGE, NUM_NODES);
	end
	if (NUM_NODES < 1 || NUM_NODES > ID_MAX_REPR) begin : g_bad_nodes
		$error("NUM_NODES %0d does not fit the node id width", NUM_NODES);
	end

	// ====================
	// Injection decode
	// ====================

	// One-hot strobe per node, index k belongs to node id k+1
	// Ids 0 and above NUM_NODES match no entry and are ignored
	logic [NUM_NODES-1:0] tx_sel;

	always_comb begin
		for (int k = 0; k < NUM_NODES; k++) begin
			tx_sel[k] = tx_strobe_i && (tx_node_i == node_id_t'(k + 1));
		end
	end

	// ====================
	// Ring of nodes
	// ====================

	// Slot leaving each node, index k is node id k+1
	packet_t [NUM_NODES-1:0] ring;

	for (genvar k = 0; k < NUM_NODES; k++) begin : g_node
		// The first node closes the loop from the last one
		localparam int PREV = (k == 0) ? NUM_NODES - 1 : k - 1;

		nic_node #(
			.NODE_ID (k + 1),
			.MAX_AGE (MAX_AGE)
		) u_node (
			.clk_i         (clk_i),
			.reset_i       (reset_i),
			.ring_i        (ring[PREV]),
			.ring_o        (ring[k]),
			.tx_strobe_i   (tx_sel[k]),
			.tx_packet_i   (tx_packet_i),
			.tx_busy_o     (tx_busy_o[k]),
			.tx_overflow_o (tx_overflow_o[k]),
			.rx_strobe_o   (rx_strobe_o[k]),
			.drop_strobe_o (drop_strobe_o[k]),
			.rx_packet_o   (rx_packet_o[k])
		);
	end

endmodule

// ==== bench/tb_clock.sv ====
// Clock and reset source for the ring testbench
// Gives a free-running clock and a synchronous reset held for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset leaves on a rising edge, like any other synchronous input
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

// ==== bench/nic_ring_properties.sv ====
// Concurrent checks on one ring stop
// Bound into every nic_node from the testbench top, so each node is watched on its own

`timescale 1ns/1ps

module nic_ring_properties #(
	parameter int MAX_AGE = 7
) (
	input logic             clk_i,
	input logic             reset_i,
	input logic             tx_strobe_i,
	input logic             tx_busy_o,
	input logic             tx_overflow_o,
	input logic             rx_strobe_o,
	input logic             drop_strobe_o,
	input nic_pkg::packet_t ring_i
);

	import nic_pkg::*;

	// A slot is either delivered or discarded, never both
	a_rx_drop_excl : assert property (@(posedge clk_i) disable iff (reset_i)
		!(rx_strobe_o && drop_strobe_o))
		else $error("delivery and drop flagged in the same cycle");

	// An overflow pulse needs a strobe that met a busy node one cycle before
	a_overflow_cause : assert property (@(posedge clk_i) disable iff (reset_i)
		tx_overflow_o |-> $past(tx_strobe_i && tx_busy_o))
		else $error("overflow without a strobe against a busy node");

	// A packet that arrives at MAX_AGE ends here, so no slot travels on past the limit
	a_age_bound : assert property (@(posedge clk_i) disable iff (reset_i)
		(pkt_valid(ring_i) && (ring_i.age == age_t'(MAX_AGE))) |=>
		(rx_strobe_o || drop_strobe_o))
		else $error("packet at the age limit was neither delivered nor dropped");

endmodule

// ==== bench/nic_ring_tb.sv ====
// Directed testbench for the slotted ring
// Runs reset, delivery, aging, overflow and random traffic tests against nic_ring
// Expected timing and counts come from the hop and age rules of the ring

`timescale 1ns/1ps

module nic_ring_tb;

	import nic_pkg::*;

	localparam int NUM_NODES    = 4;
	localparam int MAX_AGE      = 7;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_PKTS     = 200;
	// Upper bound in cycles for any single wait
	localparam int TEST_BOUND   = 4 * NUM_NODES * MAX_AGE;
	// Whole run bound, one test length per injection plus margin
	localparam longint WATCHDOG_NS =
		longint'(RESET_CYCLES + (8 + NUM_NODES * NUM_NODES + NUM_PKTS) * TEST_BOUND) * 20;

	logic                            clk;
	logic                            reset;
	logic                            tx_strobe;
	node_id_t                        tx_node;
	packet_t                         tx_packet;
	logic            [NUM_NODES-1:0] rx_strobe;
	logic            [NUM_NODES-1:0] drop_strobe;
	logic            [NUM_NODES-1:0] tx_busy;
	logic            [NUM_NODES-1:0] tx_overflow;
	packet_t         [NUM_NODES-1:0] rx_packet;

	tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk_o   (clk),
		.reset_o (reset)
	);

	nic_ring #(.NUM_NODES(NUM_NODES), .MAX_AGE(MAX_AGE)) u_dut (
		.clk_i         (clk),
		.reset_i       (reset),
		.tx_strobe_i   (tx_strobe),
		.tx_node_i     (tx_node),
		.tx_packet_i   (tx_packet),
		.rx_strobe_o   (rx_strobe),
		.drop_strobe_o (drop_strobe),
		.tx_busy_o     (tx_busy),
		.tx_overflow_o (tx_overflow),
		.rx_packet_o   (rx_packet)
	);

	bind nic_node nic_ring_properties #(.MAX_AGE(MAX_AGE)) u_props (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.tx_strobe_i   (tx_strobe_i),
		.tx_busy_o     (tx_busy_o),
		.tx_overflow_o (tx_overflow_o),
		.rx_strobe_o   (rx_strobe_o),
		.drop_strobe_o (drop_strobe_o),
		.ring_i        (ring_i)
	);

	// ====================
	// Event logs
	// ====================

	integer  seed = 23629;
	int      errors = 0;
	int      tests = 0;
	int      cyc = 0;
	packet_t rx_log[$];
	int      rx_node_log[$];
	int      rx_cyc_log[$];
	int      drop_node_log[$];
	int      drop_cyc_log[$];
	int      ovf_cnt[NUM_NODES];

	always @(posedge clk) cyc <= cyc + 1;

	// Outputs are sampled mid-cycle where they are settled
	always @(negedge clk) begin
		if (!reset) begin
			for (int k = 0; k < NUM_NODES; k++) begin
				if (rx_strobe[k]) begin
					rx_log.push_back(rx_packet[k]);
					rx_node_log.push_back(k + 1);
					rx_cyc_log.push_back(cyc);
				end
				if (drop_strobe[k]) begin
					drop_node_log.push_back(k + 1);
					drop_cyc_log.push_back(cyc);
				end
				if (tx_overflow[k]) ovf_cnt[k]++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the run did not finish", $time);
		$display("Regression failed");
		$finish;
	end

	// ====================
	// Helpers
	// ====================

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		errors++;
	endtask

	task automatic clear_logs();
		rx_log.delete();
		rx_node_log.delete();
		rx_cyc_log.delete();
		drop_node_log.delete();
		drop_cyc_log.delete();
		for (int k = 0; k < NUM_NODES; k++) ovf_cnt[k] = 0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// Strobes one packet in, then finds the cycle where the held packet enters the ring
	task automatic inject(input int src, input packet_t pkt, output int ins_cyc);
		int waited;
		@(posedge clk);
		tx_strobe <= 1'b1;
		tx_node   <= node_id_t'(src);
		tx_packet <= pkt;
		@(posedge clk);
		tx_strobe <= 1'b0;
		waited = 0;
		ins_cyc = -1;
		while (ins_cyc < 0 && waited < TEST_BOUND) begin
			@(negedge clk);
			if (!tx_busy[src-1]) ins_cyc = cyc;
			waited++;
		end
		if (ins_cyc < 0) begin
			$display("node %0d never placed its packet on the ring", src);
			errors++;
		end
	endtask

	task automatic wait_for_logs(input int n_rx, input int n_drop);
		int waited;
		waited = 0;
		while ((rx_log.size() < n_rx || drop_node_log.size() < n_drop) &&
		       waited < TEST_BOUND) begin
			@(posedge clk);
			waited++;
		end
		if (waited >= TEST_BOUND) begin
			$display("timed out waiting for %0d deliveries and %0d drops", n_rx, n_drop);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) $display("test %s: ok", name);
		else $display("test %s: FAILED with %0d errors", name, errors - err_before);
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		clear_logs();
		@(negedge clk);
		if (rx_strobe !== '0) report_mismatch("rx_strobe_o", rx_strobe, 0);
		if (drop_strobe !== '0) report_mismatch("drop_strobe_o", drop_strobe, 0);
		if (tx_busy !== '0) report_mismatch("tx_busy_o", tx_busy, 0);
		if (tx_overflow !== '0) report_mismatch("tx_overflow_o", tx_overflow, 0);
		idle_cycles(2 * NUM_NODES);
		if (rx_log.size() != 0) report_mismatch("rx_strobe_o count", rx_log.size(), 0);
		finish_test("reset_state", e0);
	endtask

	task automatic test_single_delivery();
		int e0;
		int ins;
		int h;
		packet_t pkt;
		e0 = errors;
		for (int s = 1; s <= NUM_NODES; s++) begin
			for (int d = 1; d <= NUM_NODES; d++) begin
				clear_logs();
				// Junk in sid and age shows that the node stamps both
				pkt = packet_t'($random(seed));
				pkt.did = node_id_t'(d);
				inject(s, pkt, ins);
				h = (d == s) ? NUM_NODES : (d - s + NUM_NODES) % NUM_NODES;
				wait_for_logs(1, 0);
				idle_cycles(NUM_NODES);
				if (rx_log.size() != 1) begin
					report_mismatch("rx_strobe_o count", rx_log.size(), 1);
				end else begin
					if (rx_node_log[0] != d) report_mismatch("rx node", rx_node_log[0], d);
					if (rx_cyc_log[0] != ins + h) report_mismatch("rx cycle", rx_cyc_log[0], ins + h);
					if (rx_log[0].sid != s) report_mismatch("rx_packet_o.sid", rx_log[0].sid, s);
					if (rx_log[0].did != d) report_mismatch("rx_packet_o.did", rx_log[0].did, d);
					if (rx_log[0].typ != pkt.typ) report_mismatch("rx_packet_o.typ", rx_log[0].typ, pkt.typ);
					if (rx_log[0].age != h - 1) report_mismatch("rx_packet_o.age", rx_log[0].age, h - 1);
				end
			end
		end
		finish_test("single_delivery", e0);
	endtask

	task automatic test_aging_discard();
		int e0;
		int ins;
		int s;
		int exp_node;
		packet_t pkt;
		e0 = errors;
		clear_logs();
		s = 1 + {$random(seed)} % NUM_NODES;
		pkt = packet_t'($random(seed));
		pkt.did = node_id_t'(NUM_NODES + 5);
		inject(s, pkt, ins);
		// The discard happens on the hop after the packet reaches MAX_AGE
		exp_node = ((s - 1 + MAX_AGE + 1) % NUM_NODES) + 1;
		wait_for_logs(0, 1);
		idle_cycles(NUM_NODES);
		if (rx_log.size() != 0) report_mismatch("rx_strobe_o count", rx_log.size(), 0);
		if (drop_node_log.size() != 1) begin
			report_mismatch("drop_strobe_o count", drop_node_log.size(), 1);
		end else begin
			if (drop_node_log[0] != exp_node) report_mismatch("drop node", drop_node_log[0], exp_node);
			if (drop_cyc_log[0] != ins + MAX_AGE + 1) begin
				report_mismatch("drop cycle", drop_cyc_log[0], ins + MAX_AGE + 1);
			end
		end
		finish_test("aging_discard", e0);
	endtask

	task automatic test_overflow();
		int e0;
		int others;
		packet_t pkt;
		e0 = errors;
		clear_logs();
		// Node 1 fills one slot per cycle, then node 2 gets two strobes into a full ring
		for (int i = 0; i < NUM_NODES + 2; i++) begin
			@(posedge clk);
			pkt = packet_t'($random(seed));
			pkt.did = (i < NUM_NODES) ? node_id_t'(NUM_NODES + 5) : node_id_t'(3);
			pkt.typ = (i == NUM_NODES) ? pkt_type_t'(6'h2a) : pkt_type_t'(6'h15);
			tx_strobe <= 1'b1;
			tx_node   <= (i < NUM_NODES) ? node_id_t'(1) : node_id_t'(2);
			tx_packet <= pkt;
		end
		@(posedge clk);
		tx_strobe <= 1'b0;
		wait_for_logs(1, NUM_NODES);
		idle_cycles(2 * MAX_AGE);
		others = 0;
		for (int k = 0; k < NUM_NODES; k++) if (k != 1) others += ovf_cnt[k];
		if (ovf_cnt[1] != 1) report_mismatch("tx_overflow_o[1] cycles", ovf_cnt[1], 1);
		if (others != 0) report_mismatch("tx_overflow_o other nodes", others, 0);
		if (drop_node_log.size() != NUM_NODES) begin
			report_mismatch("drop_strobe_o count", drop_node_log.size(), NUM_NODES);
		end
		if (rx_log.size() != 1) begin
			report_mismatch("rx_strobe_o count", rx_log.size(), 1);
		end else begin
			if (rx_node_log[0] != 3) report_mismatch("rx node", rx_node_log[0], 3);
			if (rx_log[0].sid != 2) report_mismatch("rx_packet_o.sid", rx_log[0].sid, 2);
			if (rx_log[0].typ != 6'h2a) report_mismatch("rx_packet_o.typ", rx_log[0].typ, 6'h2a);
		end
		finish_test("overflow", e0);
	endtask

	task automatic test_random_traffic();
		int e0;
		int ins;
		int src;
		int n_rx;
		int n_drop;
		int exp_rx[NUM_NODES];
		int exp_drop[NUM_NODES];
		int got_rx[NUM_NODES];
		int got_drop[NUM_NODES];
		int found;
		packet_t pkt;
		packet_t expect_q[$];
		e0 = errors;
		clear_logs();
		n_rx = 0;
		n_drop = 0;
		for (int k = 0; k < NUM_NODES; k++) begin
			exp_rx[k] = 0;
			exp_drop[k] = 0;
			got_rx[k] = 0;
			got_drop[k] = 0;
		end
		for (int i = 0; i < NUM_PKTS; i++) begin
			src = 1 + {$random(seed)} % NUM_NODES;
			pkt = packet_t'($random(seed));
			// Ids 0 and above NUM_NODES are missing nodes
			pkt.did = node_id_t'({$random(seed)} % (NUM_NODES + 3));
			inject(src, pkt, ins);
			if (pkt.did >= 1 && pkt.did <= NUM_NODES) begin
				exp_rx[pkt.did-1]++;
				n_rx++;
				pkt.sid = node_id_t'(src);
				expect_q.push_back(pkt);
			end else begin
				exp_drop[(src - 1 + MAX_AGE + 1) % NUM_NODES]++;
				n_drop++;
			end
			idle_cycles({$random(seed)} % 4);
		end
		wait_for_logs(n_rx, n_drop);
		idle_cycles(MAX_AGE + NUM_NODES);
		foreach (rx_node_log[i]) got_rx[rx_node_log[i]-1]++;
		foreach (drop_node_log[i]) got_drop[drop_node_log[i]-1]++;
		for (int k = 0; k < NUM_NODES; k++) begin
			if (got_rx[k] != exp_rx[k]) report_mismatch($sformatf("rx_strobe_o[%0d] count", k),
				got_rx[k], exp_rx[k]);
			if (got_drop[k] != exp_drop[k]) report_mismatch(
				$sformatf("drop_strobe_o[%0d] count", k), got_drop[k], exp_drop[k]);
		end
		// Each delivered packet uses up one expected packet
		foreach (rx_log[i]) begin
			found = -1;
			foreach (expect_q[j]) begin
				if (found < 0 && expect_q[j].did == rx_log[i].did &&
				    expect_q[j].sid == rx_log[i].sid && expect_q[j].typ == rx_log[i].typ) begin
					found = j;
				end
			end
			if (found < 0) begin
				$display("delivered packet sid %0d did %0d typ %0h matches no sent packet",
					rx_log[i].sid, rx_log[i].did, rx_log[i].typ);
				errors++;
			end else begin
				expect_q.delete(found);
			end
		end
		finish_test("random_traffic", e0);
	endtask

	// ====================
	// Sequence
	// ====================

	initial begin
		tx_strobe = 1'b0;
		tx_node   = '0;
		tx_packet = '0;
		wait (reset == 1'b0);
		@(posedge clk);
		test_reset_state();
		test_single_delivery();
		test_aging_discard();
		test_overflow();
		test_random_traffic();
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
common/nic_pkg.sv
nic/nic_ager.sv
nic/nic_rx_match.sv
nic/nic_node.sv
hdl/nic_ring.sv
bench/tb_clock.sv
bench/nic_ring_properties.sv
bench/nic_ring_tb.sv

// ==== Makefile ====
# Verilator build and run for the slotted ring testbench
# Override any variable on the command line, e.g. make TOP=nic_ring_tb LOG=run.log

VERILATOR ?= verilator
TOP       ?= nic_ring_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The log search decides the result, so a failing run returns nonzero
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
